// ==== hw/opll_chan_regs.sv ====
`timescale 1ns/100ps

module opll_chan_regs
	import opll_pkg::*;
	(
	input logic MCLK,
	input logic rst_n,
	input logic pend_valid,
	input chan_t pend_chan,
	input logic pend_hi,
	input bus_data_t pend_data,
	input chan_t cur_chan,
	output logic pend_done,
	output fnum_t cur_fnum,
	output block_t cur_block,
	output logic cur_key
	);

	fnum_t fnum_mem [NUM_CHANNELS];
	block_t block_mem [NUM_CHANNELS];
	logic key_mem [NUM_CHANNELS];

	// write lands only when the rotation reaches the target channel
	assign pend_done = pend_valid & (pend_chan == cur_chan);

	always_ff @(posedge MCLK)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_CHANNELS; i++)
			begin
				fnum_mem[i] <= '0;
				block_mem[i] <= '0;
				key_mem[i] <= 1'b0;
			end
		end
		else if (pend_done)
		begin
			if (pend_hi)
			begin
				// 0x2n holds key, block and fnum msb
				fnum_mem[pend_chan][8] <= pend_data[0];
				block_mem[pend_chan] <= pend_data[3:1];
				key_mem[pend_chan] <= pend_data[4];
			end
			else
			begin
				fnum_mem[pend_chan][7:0] <= pend_data;
			end
		end
	end

	assign cur_fnum = fnum_mem[cur_chan];
	assign cur_block = block_mem[cur_chan];
	assign cur_key = key_mem[cur_chan];

endmodule

// ==== hw/opll_host_port.sv ====
`timescale 1ns/100ps

module opll_host_port
	import opll_pkg::*;
	(
	input logic MCLK,
	input logic rst_n,
	input logic wr_valid,
	input logic wr_a0,
	input bus_data_t wr_data,
	output logic wr_ready,
	output logic pend_valid,
	output chan_t pend_chan,
	output logic pend_hi,
	output bus_data_t pend_data,
	input logic pend_done,
	output multi_t multi_mod,
	output multi_t multi_car
	);

	bus_data_t addr_q;
	logic xfer;
	logic addr_is_fnum;
	logic addr_is_blk;
	logic addr_chan_ok;
	logic addr_is_chan;

	assign xfer = wr_valid & wr_ready;

	// host stalls while a channel write waits for its slot
	assign wr_ready = ~pend_valid;

	assign addr_is_fnum = (addr_q[7:4] == ADDR_FNUM_LO[7:4]);
	assign addr_is_blk = (addr_q[7:4] == ADDR_BLK_KEY[7:4]);
	assign addr_chan_ok = (addr_q[3:0] < NUM_CHANNELS);
	assign addr_is_chan = (addr_is_fnum | addr_is_blk) & addr_chan_ok;

	always_ff @(posedge MCLK)
	begin
		if (!rst_n)
		begin
			addr_q <= '0;
			multi_mod <= '0;
			multi_car <= '0;
		end
		else if (xfer)
		begin
			if (!wr_a0)
			begin
				addr_q <= wr_data;
			end
			else if (addr_q == ADDR_MULTI_MOD)
			begin
				multi_mod <= wr_data[3:0];
			end
			else if (addr_q == ADDR_MULTI_CAR)
			begin
				multi_car <= wr_data[3:0];
			end
		end
	end

	// pending channel write
	always_ff @(posedge MCLK)
	begin
		if (!rst_n)
		begin
			pend_valid <= 1'b0;
		end
		else if (xfer && wr_a0 && addr_is_chan)
		begin
			pend_valid <= 1'b1;
		end
		else if (pend_done)
		begin
			pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (xfer && wr_a0 && addr_is_chan)
		begin
			pend_chan <= addr_q[3:0];
			pend_hi <= addr_is_blk;
			pend_data <= wr_data;
		end
	end

endmodule

// ==== hw/opll_phase_gen.sv ====
`timescale 1ns/100ps

module opll_phase_gen
	import opll_pkg::*;
	#(
	parameter int PHASE_OUT_BITS = 19
	)
	(
	input logic MCLK,
	input logic rst_n,
	input logic seq_run,
	input slot_t cur_slot,
	input fnum_t cur_fnum,
	input block_t cur_block,
	input logic cur_key,
	input multi_t multi_mod,
	input multi_t multi_car,
	output logic out_valid,
	output slot_t out_slot,
	output logic [PHASE_OUT_BITS-1:0] out_phase
	);

	multi_t multi_sel;
	logic [4:0] multi_x2;
	logic [15:0] fnum_blk;
	logic [20:0] fnum_prod;
	phase_t phase_inc;
	phase_t phase_old;
	phase_t phase_new;
	phase_t phase_mem [NUM_SLOTS];

	// doubled multiple so that code 0 gives a half
	function automatic logic [4:0] mult_x2(input multi_t code);
		case (code)
			4'd0: mult_x2 = 5'd1;
			4'd1: mult_x2 = 5'd2;
			4'd2: mult_x2 = 5'd4;
			4'd3: mult_x2 = 5'd6;
			4'd4: mult_x2 = 5'd8;
			4'd5: mult_x2 = 5'd10;
			4'd6: mult_x2 = 5'd12;
			4'd7: mult_x2 = 5'd14;
			4'd8: mult_x2 = 5'd16;
			4'd9: mult_x2 = 5'd18;
			4'd10, 4'd11: mult_x2 = 5'd20;
			4'd12, 4'd13: mult_x2 = 5'd24;
			default: mult_x2 = 5'd30;
		endcase
	endfunction

	// modulator on even slots and carrier on odd slots
	assign multi_sel = cur_slot[0] ? multi_car : multi_mod;
	assign multi_x2 = mult_x2(multi_sel);

	assign fnum_blk = 16'(cur_fnum) << cur_block;
	assign fnum_prod = 21'(fnum_blk) * 21'(multi_x2);
	// drop the doubling and the extra factor of two
	assign phase_inc = fnum_prod[20:2];

	assign phase_old = phase_mem[cur_slot];
	// key off parks the phase at zero
	assign phase_new = cur_key ? phase_old + phase_inc : '0;

	always_ff @(posedge MCLK)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				phase_mem[i] <= '0;
			end
		end
		else if (seq_run)
		begin
			phase_mem[cur_slot] <= phase_new;
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= seq_run;
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (seq_run)
		begin
			out_slot <= cur_slot;
			out_phase <= phase_new[$bits(phase_t)-1 -: PHASE_OUT_BITS];
		end
	end

endmodule

// ==== hw/opll_phase_top.sv ====
`timescale 1ns/100ps

module opll_phase_top
	import opll_pkg::*;
	#(
	parameter int PHASE_OUT_BITS = 19
	)
	(
	input logic MCLK,
	input logic rst_n,
	input logic wr_valid,
	input logic wr_a0,
	input bus_data_t wr_data,
	output logic wr_ready,
	output logic out_valid,
	output slot_t out_slot,
	output logic [PHASE_OUT_BITS-1:0] out_phase
	);

	logic pend_valid;
	chan_t pend_chan;
	logic pend_hi;
	bus_data_t pend_data;
	logic pend_done;
	multi_t multi_mod;
	multi_t multi_car;
	slot_t cur_slot;
	chan_t cur_chan;
	logic seq_run;
	fnum_t cur_fnum;
	block_t cur_block;
	logic cur_key;

	opll_host_port host0
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.wr_valid(wr_valid),
		.wr_a0(wr_a0),
		.wr_data(wr_data),
		.wr_ready(wr_ready),
		.pend_valid(pend_valid),
		.pend_chan(pend_chan),
		.pend_hi(pend_hi),
		.pend_data(pend_data),
		.pend_done(pend_done),
		.multi_mod(multi_mod),
		.multi_car(multi_car)
	);

	opll_slot_seq seq0
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.cur_slot(cur_slot),
		.cur_chan(cur_chan),
		.seq_run(seq_run)
	);

	opll_chan_regs chregs0
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.pend_valid(pend_valid),
		.pend_chan(pend_chan),
		.pend_hi(pend_hi),
		.pend_data(pend_data),
		.cur_chan(cur_chan),
		.pend_done(pend_done),
		.cur_fnum(cur_fnum),
		.cur_block(cur_block),
		.cur_key(cur_key)
	);

	opll_phase_gen #(
		.PHASE_OUT_BITS(PHASE_OUT_BITS)
	) pg0
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.seq_run(seq_run),
		.cur_slot(cur_slot),
		.cur_fnum(cur_fnum),
		.cur_block(cur_block),
		.cur_key(cur_key),
		.multi_mod(multi_mod),
		.multi_car(multi_car),
		.out_valid(out_valid),
		.out_slot(out_slot),
		.out_phase(out_phase)
	);

endmodule

// ==== hw/opll_pkg.sv ====
package opll_pkg;

	// channel and operator slot counts
	localparam int NUM_CHANNELS = 9;
	localparam int NUM_SLOTS = 18;

	typedef logic [8:0] fnum_t;
	typedef logic [2:0] block_t;
	typedef logic [3:0] multi_t;
	typedef logic [18:0] phase_t;
	typedef logic [4:0] slot_t;
	typedef logic [3:0] chan_t;
	typedef logic [7:0] bus_data_t;

	typedef enum logic
	{
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_e;

	// custom operator multiples
	localparam bus_data_t ADDR_MULTI_MOD = 8'h00;
	localparam bus_data_t ADDR_MULTI_CAR = 8'h01;

	// channel register bases with the channel in the low nibble
	localparam bus_data_t ADDR_FNUM_LO = 8'h10;
	localparam bus_data_t ADDR_BLK_KEY = 8'h20;

endpackage

// ==== hw/opll_slot_seq.sv ====
`timescale 1ns/100ps

module opll_slot_seq
	import opll_pkg::*;
	(
	input logic MCLK,
	input logic rst_n,
	output slot_t cur_slot,
	output chan_t cur_chan,
	output logic seq_run
	);

	seq_state_e state;
	slot_t next_slot;

	assign next_slot = (cur_slot == slot_t'(NUM_SLOTS - 1)) ? '0 : cur_slot + 1'b1;
	assign seq_run = (state == SEQ_RUN);

	always_ff @(posedge MCLK)
	begin
		if (!rst_n)
		begin
			state <= SEQ_IDLE;
			cur_slot <= '0;
			cur_chan <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					// first running cycle sits on slot 0
					state <= SEQ_RUN;
				end
				SEQ_RUN:
				begin
					cur_slot <= next_slot;
					// two operators per channel
					cur_chan <= next_slot[4:1];
				end
				default:
				begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== opll_phase_top.f ====
hw/opll_pkg.sv
hw/opll_host_port.sv
hw/opll_slot_seq.sv
hw/opll_chan_regs.sv
hw/opll_phase_gen.sv
hw/opll_phase_top.sv
verification/opll_phase_assert.sv
verification/opll_phase_tb.sv

// ==== verification/opll_phase_assert.sv ====
`timescale 1ns/100ps

module opll_phase_assert
	import opll_pkg::*;
	(
	input logic MCLK,
	input logic rst_n,
	input logic wr_ready,
	input logic out_valid,
	input slot_t out_slot
	);

	int fail_count = 0;

	slot_range_chk: assert property (@(posedge MCLK) disable iff (!rst_n)
		out_valid |-> (out_slot < NUM_SLOTS))
	else
	begin
		fail_count++;
		$error("out_slot outside the slot range");
	end

	// rotation order wraps 17 to 0
	slot_order_chk: assert property (@(posedge MCLK) disable iff (!rst_n)
		(out_valid && $past(out_valid)) |->
		(out_slot == (($past(out_slot) == slot_t'(NUM_SLOTS - 1)) ? slot_t'(0)
			: slot_t'($past(out_slot) + 1'b1))))
	else
	begin
		fail_count++;
		$error("out_slot skipped a slot");
	end

	ready_return_chk: assert property (@(posedge MCLK) disable iff (!rst_n)
		$fell(wr_ready) |-> ##[1:19] wr_ready)
	else
	begin
		fail_count++;
		$error("wr_ready stayed low too long");
	end

endmodule

bind opll_phase_top opll_phase_assert assert0
(
	.MCLK(MCLK),
	.rst_n(rst_n),
	.wr_ready(wr_ready),
	.out_valid(out_valid),
	.out_slot(out_slot)
);

// ==== verification/opll_phase_tb.sv ====
`timescale 1ns/100ps

module opll_phase_tb
	import opll_pkg::*;
	();

	// directed writes and the check after the data file
	localparam int TAIL_STEPS = 5;

	logic MCLK = 1'b0;
	logic rst_n;
	logic wr_valid;
	logic wr_a0;
	bus_data_t wr_data;
	logic wr_ready;
	logic out_valid;
	slot_t out_slot;
	phase_t out_phase;

	// reference copy of the register state
	fnum_t sh_fnum [NUM_CHANNELS];
	block_t sh_block [NUM_CHANNELS];
	logic sh_key [NUM_CHANNELS];
	multi_t sh_mod;
	multi_t sh_car;
	bus_data_t sh_addr;

	byte cmd_q [$];
	int arg_a_q [$];
	int arg_b_q [$];
	int data_lines = 0;
	int random_writes = 0;
	logic load_done = 1'b0;
	logic [31:0] lcg_state = 32'd43;
	int exp_slot = 0;
	logic valid_seen = 1'b0;

	opll_phase_top #(
		.PHASE_OUT_BITS(19)
	) dut0
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.wr_valid(wr_valid),
		.wr_a0(wr_a0),
		.wr_data(wr_data),
		.wr_ready(wr_ready),
		.out_valid(out_valid),
		.out_slot(out_slot),
		.out_phase(out_phase)
	);

	always #50 MCLK = ~MCLK;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("error: %s is %h, expected %h", name, got, expected);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// f-number << block times the doubled multiple over four
	function automatic phase_t expected_inc(input fnum_t f, input block_t b, input multi_t code);
		int doubled [16];
		longint prod;
		doubled = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};
		prod = (longint'(f) << b) * doubled[code];
		return phase_t'(prod / 4);
	endfunction

	function automatic logic is_chan_addr(input bus_data_t addr);
		logic hit;
		hit = (addr[7:4] == ADDR_FNUM_LO[7:4]) || (addr[7:4] == ADDR_BLK_KEY[7:4]);
		return hit && (addr[3:0] < NUM_CHANNELS);
	endfunction

	// called and returns on a falling edge
	task automatic host_write(input logic a0, input bus_data_t data);
		int waited;
		int c;
		logic chan_write;
		chan_write = a0 && is_chan_addr(sh_addr);
		wr_valid = 1'b1;
		wr_a0 = a0;
		wr_data = data;
		waited = 0;
		while (!wr_ready)
		begin
			@(negedge MCLK);
			waited++;
			if (waited > 40)
				fail_run("host write was never accepted");
		end
		@(negedge MCLK);
		wr_valid = 1'b0;
		if (!a0)
			sh_addr = data;
		else if (sh_addr == ADDR_MULTI_MOD)
			sh_mod = data[3:0];
		else if (sh_addr == ADDR_MULTI_CAR)
			sh_car = data[3:0];
		else if (chan_write)
		begin
			c = sh_addr[3:0];
			if (sh_addr[7:4] == ADDR_BLK_KEY[7:4])
			begin
				sh_fnum[c][8] = data[0];
				sh_block[c] = data[3:1];
				sh_key[c] = data[4];
			end
			else
				sh_fnum[c][7:0] = data;
		end
		if (chan_write)
		begin
			check_value("wr_ready", wr_ready, 0);
			waited = 0;
			while (!wr_ready)
			begin
				@(negedge MCLK);
				waited++;
				if (waited > 19)
					fail_run("channel write did not complete within 19 cycles");
			end
		end
		else
			check_value("wr_ready", wr_ready, 1);
	endtask

	// two samples per slot one rotation apart
	task automatic measure_channel(input int chan);
		phase_t ph_mod [2];
		phase_t ph_car [2];
		int n_mod;
		int n_car;
		int guard;
		int s_mod;
		n_mod = 0;
		n_car = 0;
		guard = 0;
		s_mod = 2 * chan;
		repeat (NUM_SLOTS) @(negedge MCLK);
		while (n_mod < 2 || n_car < 2)
		begin
			@(negedge MCLK);
			guard++;
			if (guard > 60)
				fail_run("channel slots did not show up on the output");
			if (out_valid && out_slot == s_mod && n_mod < 2)
			begin
				ph_mod[n_mod] = out_phase;
				n_mod++;
			end
			if (out_valid && out_slot == s_mod + 1 && n_car < 2)
			begin
				ph_car[n_car] = out_phase;
				n_car++;
			end
		end
		if (sh_key[chan])
		begin
			check_value($sformatf("out_phase slot %0d increment", s_mod),
				phase_t'(ph_mod[1] - ph_mod[0]),
				expected_inc(sh_fnum[chan], sh_block[chan], sh_mod));
			check_value($sformatf("out_phase slot %0d increment", s_mod + 1),
				phase_t'(ph_car[1] - ph_car[0]),
				expected_inc(sh_fnum[chan], sh_block[chan], sh_car));
		end
		else
		begin
			check_value($sformatf("out_phase slot %0d", s_mod), ph_mod[0] | ph_mod[1], 0);
			check_value($sformatf("out_phase slot %0d", s_mod + 1), ph_car[0] | ph_car[1], 0);
		end
	endtask

	task automatic random_channel(input int chan);
		logic [31:0] r;
		logic [31:0] rf;
		r = lcg_next();
		rf = lcg_next();
		host_write(1'b0, ADDR_MULTI_MOD);
		host_write(1'b1, {4'h0, r[27:24]});
		host_write(1'b0, ADDR_MULTI_CAR);
		host_write(1'b1, {4'h0, r[23:20]});
		host_write(1'b0, ADDR_FNUM_LO + bus_data_t'(chan));
		host_write(1'b1, rf[23:16]);
		host_write(1'b0, ADDR_BLK_KEY + bus_data_t'(chan));
		host_write(1'b1, {3'b000, 1'b1, r[18:16], rf[24]});
		measure_channel(chan);
	endtask

	// slot order on the output stream
	always @(negedge MCLK)
	begin
		if (!rst_n)
		begin
			exp_slot = 0;
			valid_seen = 1'b0;
		end
		else if (out_valid)
		begin
			check_value("out_slot", out_slot, exp_slot);
			exp_slot = (exp_slot == NUM_SLOTS - 1) ? 0 : exp_slot + 1;
			valid_seen = 1'b1;
		end
		else if (valid_seen)
			fail_run("out_valid dropped while the sequencer was running");
	end

	initial
	begin
		longint limit_ns;
		wait (load_done);
		limit_ns = longint'(data_lines + random_writes + TAIL_STEPS) * 40 * 100;
		#(limit_ns);
		$display("timeout after %0d ns, the test did not finish", limit_ns);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		int fd;
		int n;
		int a;
		int b;
		byte cmd;
		string line;
		wr_valid = 1'b0;
		wr_a0 = 1'b0;
		wr_data = '0;
		rst_n = 1'b0;
		sh_mod = '0;
		sh_car = '0;
		sh_addr = '0;
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			sh_fnum[i] = '0;
			sh_block[i] = '0;
			sh_key[i] = 1'b0;
		end
		fd = $fopen("verification/opll_phase_testdata.txt", "r");
		if (fd == 0)
			fail_run("cannot open the test data file");
		while ($fgets(line, fd) != 0)
		begin
			n = $sscanf(line, "%c %h %h", cmd, a, b);
			if (n >= 2 && cmd != "#")
			begin
				cmd_q.push_back(cmd);
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				data_lines++;
				if (cmd == "r")
					random_writes += 8;
			end
		end
		$fclose(fd);
		load_done = 1'b1;
		repeat (5) @(posedge MCLK);
		@(negedge MCLK);
		rst_n = 1'b1;
		foreach (cmd_q[i])
		begin
			a = arg_a_q[i];
			b = arg_b_q[i];
			case (cmd_q[i])
				"w": host_write(a[0], b[7:0]);
				"c": measure_channel(a);
				"r": random_channel(a);
				default: fail_run("unknown directive in the test data");
			endcase
		end
		// codes 12 and 13 share one factor
		host_write(1'b0, ADDR_MULTI_MOD);
		host_write(1'b1, 8'h0c);
		host_write(1'b0, ADDR_MULTI_CAR);
		host_write(1'b1, 8'h0d);
		measure_channel(3);
		check_value("assertion failures", dut0.assert0.fail_count, 0);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== verification/opll_phase_testdata.txt ====
# w <a0> <data hex> : host write, a0 0 = address, 1 = data
# c <chan> : check both slots of a channel, r <chan> : random setup then check
c 0
w 0 00
w 1 01
w 0 01
w 1 02
w 0 10
w 1 40
w 0 20
w 1 18
c 0
c 1
w 0 13
w 1 c8
w 0 23
w 1 15
c 3
c 0
# code 0 against code 1
w 0 00
w 1 00
c 0
w 0 00
w 1 0a
w 0 01
w 1 0b
c 3
w 0 00
w 1 0e
w 0 01
w 1 0f
c 0
# unmapped addresses and channels 9 to 15
w 0 19
w 1 ff
w 0 2f
w 1 ff
w 0 35
w 1 ff
w 0 05
w 1 07
c 0
c 3
c 8
w 0 20
w 1 08
c 0
r 5
r 8
r 2
